/* logic/boolFuncPkg.sv */
package boolFuncPkg;

    // Four-variable monotone functions held as truth tables
    localparam int VAR_COUNT = 4;
    localparam int BOT_BITS = 1 << VAR_COUNT;

    // Lane 0 is the identity, lane k swaps variable 0 with variable k
    localparam int LANE_COUNT = VAR_COUNT;

    // Bit i holds the function value at the input whose variable bits form i
    typedef logic [BOT_BITS-1:0] botT;

    // Exchange variables varA and varB of a function
    function automatic botT swapVars(botT b, int unsigned varA, int unsigned varB);
        botT result;
        logic [VAR_COUNT-1:0] idx;
        logic [VAR_COUNT-1:0] src;
        for (int i = 0; i < BOT_BITS; i++) begin
            idx = VAR_COUNT'(i);
            src = idx;
            // Read the value from the input with the two variable bits exchanged
            src[varA] = idx[varB];
            src[varB] = idx[varA];
            result[i] = b[src];
        end
        return result;
    endfunction

endpackage

/* logic/resultPkg.sv */
package resultPkg;

    // Largest supported batch
    localparam int MAX_BATCH = 64;

    // Result widths per lane and after the four-lane reduction
    localparam int LANE_SUM_BITS = 12;
    localparam int LANE_COUNT_BITS = 8;
    localparam int TOTAL_SUM_BITS = LANE_SUM_BITS + 2;
    localparam int TOTAL_COUNT_BITS = LANE_COUNT_BITS + 2;

    typedef logic [LANE_SUM_BITS-1:0] laneSumT;
    typedef logic [LANE_COUNT_BITS-1:0] laneCountT;
    typedef logic [TOTAL_SUM_BITS-1:0] totalSumT;
    typedef logic [TOTAL_COUNT_BITS-1:0] totalCountT;

    // Result memory read and adder tree latencies in cycles
    localparam int BUFFER_READ_LATENCY = 1;
    localparam int SUM_TREE_STAGES = 2;

endpackage

/* logic/delayLine.sv */
`timescale 1ns/10ps

module delayLine #(
    parameter int CYCLES = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic in,
    output logic out
);
    logic [CYCLES-1:0] stages;

    always_ff @(posedge clk) begin
        if (rst) begin
            stages <= '0;
        end else begin
            stages[0] <= in;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[CYCLES-1];

endmodule

/* logic/botFifo.sv */
`timescale 1ns/10ps

module botFifo
    import boolFuncPkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 5
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  botT  pushBot,
    input  logic pushBatchEnd,
    input  logic stall,
    output logic almostFull,
    output logic popValid,
    output botT  popBot,
    output logic popBatchEnd
);
    localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;
    // Leaves room for the writer's reaction time
    localparam int ALMOST_FULL_LEVEL = FIFO_DEPTH - 4;

    botT  botMem [FIFO_DEPTH];
    logic batchEndMem [FIFO_DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wrPtr;
    logic [FIFO_DEPTH_LOG2-1:0] rdPtr;
    logic [FIFO_DEPTH_LOG2:0] occupancy;
    logic doPush;
    logic doPop;

    assign doPush = push && (occupancy != FIFO_DEPTH);
    assign doPop = (occupancy != 0) && !stall;
    assign almostFull = occupancy >= ALMOST_FULL_LEVEL;

    always_ff @(posedge clk) begin
        if (doPush) begin
            botMem[wrPtr] <= pushBot;
            batchEndMem[wrPtr] <= pushBatchEnd;
        end
        // Registered output stage
        if (doPop) begin
            popBot <= botMem[rdPtr];
            popBatchEnd <= batchEndMem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
            popValid <= 1'b0;
        end else begin
            popValid <= doPop;
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

/* logic/variableSwapper.sv */
`timescale 1ns/10ps

module variableSwapper
    import boolFuncPkg::*;
#(
    parameter int SWAP_VAR = 0
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  botT  inBot,
    input  logic inBatchEnd,
    output logic outValid,
    output botT  outBot,
    output logic outBatchEnd
);
    botT swapped;

    // SWAP_VAR of 0 leaves the bot unchanged
    assign swapped = swapVars(inBot, 0, SWAP_VAR);

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        outBot <= swapped;
        outBatchEnd <= inBatchEnd;
    end

endmodule

/* logic/subsetAccumulator.sv */
`timescale 1ns/10ps

module subsetAccumulator
    import boolFuncPkg::*;
    import resultPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  botT       top,
    input  logic      inValid,
    input  botT       inBot,
    input  logic      inBatchEnd,
    output logic      resultWrite,
    output laneSumT   laneSum,
    output laneCountT laneCount
);
    logic      isSubset;
    laneSumT   uncovered;
    laneSumT   sumAcc;
    laneSumT   nextSum;
    laneCountT countAcc;
    laneCountT nextCount;

    // A bot is a subset when it sets no bit outside top
    assign isSubset = (inBot & ~top) == '0;
    // Top bits left uncovered by the bot
    assign uncovered = laneSumT'($countones(top & ~inBot));

    always_comb begin
        nextSum = sumAcc;
        nextCount = countAcc;
        if (isSubset) begin
            nextSum = sumAcc + uncovered;
            nextCount = countAcc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sumAcc <= '0;
            countAcc <= '0;
            resultWrite <= 1'b0;
        end else begin
            resultWrite <= inValid && inBatchEnd;
            if (inValid) begin
                // Batch end restarts the totals for the next batch
                if (inBatchEnd) begin
                    sumAcc <= '0;
                    countAcc <= '0;
                end else begin
                    sumAcc <= nextSum;
                    countAcc <= nextCount;
                end
            end
        end
    end

    // Final batch totals, presented with resultWrite
    always_ff @(posedge clk) begin
        if (inValid && inBatchEnd) begin
            laneSum <= nextSum;
            laneCount <= nextCount;
        end
    end

endmodule

/* logic/resultBuffer.sv */
`timescale 1ns/10ps

module resultBuffer
    import boolFuncPkg::*;
    import resultPkg::*;
#(
    parameter int BUFFER_DEPTH_LOG2 = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      write,
    input  laneSumT   laneSums [LANE_COUNT],
    input  laneCountT laneCounts [LANE_COUNT],
    input  logic      slowDown,
    output logic      stallLanes,
    output logic      readStrobe,
    output laneSumT   readSums [LANE_COUNT],
    output laneCountT readCounts [LANE_COUNT]
);
    localparam int BUFFER_DEPTH = 1 << BUFFER_DEPTH_LOG2;
    // Margin for results still in the swapper and accumulator stages
    localparam int STALL_LEVEL = BUFFER_DEPTH - 6;

    laneSumT   sumMem [LANE_COUNT][BUFFER_DEPTH];
    laneCountT countMem [LANE_COUNT][BUFFER_DEPTH];
    logic [BUFFER_DEPTH_LOG2-1:0] wrPtr;
    logic [BUFFER_DEPTH_LOG2-1:0] rdPtr;
    logic [BUFFER_DEPTH_LOG2:0] occupancy;
    logic slowDownReg;

    assign readStrobe = (occupancy != 0) && !slowDownReg;

    // Lanes run in lockstep and share both pointers
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < LANE_COUNT; lane++) begin
            if (write) begin
                sumMem[lane][wrPtr] <= laneSums[lane];
                countMem[lane][wrPtr] <= laneCounts[lane];
            end
            if (readStrobe) begin
                readSums[lane] <= sumMem[lane][rdPtr];
                readCounts[lane] <= countMem[lane][rdPtr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            occupancy <= '0;
            slowDownReg <= 1'b0;
            stallLanes <= 1'b0;
        end else begin
            slowDownReg <= slowDown;
            stallLanes <= occupancy >= STALL_LEVEL;
            if (write) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (readStrobe) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({write, readStrobe})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

/* logic/sumTree.sv */
`timescale 1ns/10ps

module sumTree
    import boolFuncPkg::*;
    import resultPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  laneSumT    laneSums [LANE_COUNT],
    input  laneCountT  laneCounts [LANE_COUNT],
    output totalSumT   pcoeffSum,
    output totalCountT pcoeffCount
);
    localparam int PAIR_COUNT = LANE_COUNT / 2;

    // One extra bit per stage
    logic [$bits(laneSumT):0]   pairSums [PAIR_COUNT];
    logic [$bits(laneCountT):0] pairCounts [PAIR_COUNT];

    // Stage one, lanes 0 with 1 and 2 with 3
    for (genvar p = 0; p < PAIR_COUNT; p++) begin : gPair
        always_ff @(posedge clk) begin
            if (rst) begin
                pairSums[p] <= '0;
                pairCounts[p] <= '0;
            end else begin
                pairSums[p] <= laneSums[2*p] + laneSums[2*p+1];
                pairCounts[p] <= laneCounts[2*p] + laneCounts[2*p+1];
            end
        end
    end

    // Stage two into the output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            pcoeffSum <= '0;
            pcoeffCount <= '0;
        end else begin
            pcoeffSum <= pairSums[0] + pairSums[1];
            pcoeffCount <= pairCounts[0] + pairCounts[1];
        end
    end

endmodule

/* logic/permutationPipeline.sv */
`timescale 1ns/10ps

module permutationPipeline
    import boolFuncPkg::*;
    import resultPkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 5,
    parameter int BUFFER_DEPTH_LOG2 = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       writeTop,
    input  botT        top,
    input  logic       writeBot,
    input  botT        bot,
    input  logic       batchEnd,
    output logic       almostFull,
    input  logic       slowDown,
    output logic       resultValid,
    output totalSumT   pcoeffSum,
    output totalCountT pcoeffCount
);
    botT  topReg;
    logic laneValid;
    botT  laneBot;
    logic laneBatchEnd;
    logic stallLanes;

    logic [LANE_COUNT-1:0] swapValid;
    logic [LANE_COUNT-1:0] swapBatchEnd;
    botT  swappedBot [LANE_COUNT];

    logic [LANE_COUNT-1:0] laneResultWrite;
    laneSumT   laneSum [LANE_COUNT];
    laneCountT laneCount [LANE_COUNT];

    logic      readStrobe;
    laneSumT   readSums [LANE_COUNT];
    laneCountT readCounts [LANE_COUNT];

    // Top is only reloaded while the pipeline is drained
    always_ff @(posedge clk) begin
        if (writeTop) begin
            topReg <= top;
        end
    end

    botFifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) inputFifo (
        .clk(clk),
        .rst(rst),
        .push(writeBot),
        .pushBot(bot),
        .pushBatchEnd(batchEnd),
        .stall(stallLanes),
        .almostFull(almostFull),
        .popValid(laneValid),
        .popBot(laneBot),
        .popBatchEnd(laneBatchEnd)
    );

    // One lane per variable, lane 0 passes the bot unchanged
    for (genvar k = 0; k < LANE_COUNT; k++) begin : gLane
        variableSwapper #(
            .SWAP_VAR(k)
        ) swapper (
            .clk(clk),
            .rst(rst),
            .inValid(laneValid),
            .inBot(laneBot),
            .inBatchEnd(laneBatchEnd),
            .outValid(swapValid[k]),
            .outBot(swappedBot[k]),
            .outBatchEnd(swapBatchEnd[k])
        );

        subsetAccumulator accumulator (
            .clk(clk),
            .rst(rst),
            .top(topReg),
            .inValid(swapValid[k]),
            .inBot(swappedBot[k]),
            .inBatchEnd(swapBatchEnd[k]),
            .resultWrite(laneResultWrite[k]),
            .laneSum(laneSum[k]),
            .laneCount(laneCount[k])
        );
    end

    // Lockstep lanes, all write strobes coincide
    resultBuffer #(
        .BUFFER_DEPTH_LOG2(BUFFER_DEPTH_LOG2)
    ) buffer (
        .clk(clk),
        .rst(rst),
        .write(&laneResultWrite),
        .laneSums(laneSum),
        .laneCounts(laneCount),
        .slowDown(slowDown),
        .stallLanes(stallLanes),
        .readStrobe(readStrobe),
        .readSums(readSums),
        .readCounts(readCounts)
    );

    sumTree reduction (
        .clk(clk),
        .rst(rst),
        .laneSums(readSums),
        .laneCounts(readCounts),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    // Read strobe aligned with the adder tree output
    delayLine #(
        .CYCLES(BUFFER_READ_LATENCY + SUM_TREE_STAGES)
    ) validDelay (
        .clk(clk),
        .rst(rst),
        .in(readStrobe),
        .out(resultValid)
    );

endmodule

/* sim/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Generator state
bit [31:0] randState = 32'hf67a_2c95;

// Expected results in batch order
totalSumT   expectSums [$];
totalCountT expectCounts [$];

// Totals of the batch being built
totalSumT   batchSum = '0;
totalCountT batchCount = '0;

function automatic bit [31:0] xorshift32();
    randState ^= randState << 13;
    randState ^= randState >> 17;
    randState ^= randState << 5;
    return randState;
endfunction

// Sparse random truth table
function automatic botT randomBot();
    bit [31:0] r;
    r = xorshift32();
    return r[15:0] & r[31:16];
endfunction

// Runs one item through all four lanes of the model
function automatic void modelItem(botT topBits, botT item, bit isEnd);
    botT variant;
    int  misses;
    int  uncovered;
    for (int lane = 0; lane < LANE_COUNT; lane++) begin
        variant = swapVars(item, 0, lane);
        misses = 0;
        uncovered = 0;
        for (int i = 0; i < BOT_BITS; i++) begin
            if (variant[i] && !topBits[i]) begin
                misses++;
            end
            if (topBits[i] && !variant[i]) begin
                uncovered++;
            end
        end
        // Subset only when no bit falls outside top
        if (misses == 0) begin
            batchSum = batchSum + totalSumT'(uncovered);
            batchCount = batchCount + 1'b1;
        end
    end
    if (isEnd) begin
        expectSums.push_back(batchSum);
        expectCounts.push_back(batchCount);
        batchSum = '0;
        batchCount = '0;
    end
endfunction

`endif

/* sim/permutationPipelineTb.sv */
`timescale 1ns/10ps

module permutationPipelineTb
    import boolFuncPkg::*;
    import resultPkg::*;
();
    localparam int WAIT_LIMIT = 4000;

    logic       clk;
    logic       rst;
    logic       writeTop;
    botT        topValue;
    logic       writeBot;
    botT        botValue;
    logic       batchEnd;
    logic       almostFull;
    logic       slowDown;
    logic       resultValid;
    totalSumT   pcoeffSum;
    totalCountT pcoeffCount;

    int  valueErrors = 0;
    int  otherErrors = 0;
    bit  randomSlow = 1'b0;
    botT currentTop;

    `include "refModel.svh"

    permutationPipeline #(
        .FIFO_DEPTH_LOG2(5),
        .BUFFER_DEPTH_LOG2(4)
    ) dut (
        .clk(clk),
        .rst(rst),
        .writeTop(writeTop),
        .top(topValue),
        .writeBot(writeBot),
        .bot(botValue),
        .batchEnd(batchEnd),
        .almostFull(almostFull),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compareSum(totalSumT got, totalSumT expected);
        if (got !== expected) begin
            valueErrors++;
            $display("error pcoeffSum got 0x%h expected 0x%h", got, expected);
        end
    endtask

    task automatic compareCount(totalCountT got, totalCountT expected);
        if (got !== expected) begin
            valueErrors++;
            $display("error pcoeffCount got 0x%h expected 0x%h", got, expected);
        end
    endtask

    task automatic finishRun();
        $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic reportTimeout(string what);
        otherErrors++;
        $display("timeout while waiting: %s", what);
        finishRun();
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #1;
        if (randomSlow && (xorshift32() % 8 == 0)) begin
            slowDown = !slowDown;
        end
    endtask

    task automatic loadTop(botT value);
        writeTop = 1'b1;
        topValue = value;
        currentTop = value;
        nextCycle();
        writeTop = 1'b0;
    endtask

    task automatic pushItem(botT item, logic isEnd);
        int waited;
        waited = 0;
        while (almostFull && waited < WAIT_LIMIT) begin
            nextCycle();
            waited++;
        end
        if (almostFull) begin
            reportTimeout("almostFull stayed high and no item could be pushed");
        end else begin
            writeBot = 1'b1;
            botValue = item;
            batchEnd = isEnd;
            nextCycle();
            writeBot = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        randomSlow = 1'b0;
        slowDown = 1'b0;
        while (expectSums.size() != 0 && waited < WAIT_LIMIT) begin
            nextCycle();
            waited++;
        end
        if (expectSums.size() != 0) begin
            reportTimeout("expected results never arrived");
        end else begin
            // Quiet period for the monitor to catch extra results
            repeat (20) nextCycle();
        end
    endtask

    // Top is the union of all bots of the run
    task automatic runBatches(int batches, bit toggleSlow);
        botT items [$];
        bit  ends [$];
        botT unionTop;
        int  len;
        for (int b = 0; b < batches; b++) begin
            len = 1 + int'(xorshift32() % MAX_BATCH);
            for (int j = 0; j < len; j++) begin
                items.push_back(randomBot());
                ends.push_back(j == len - 1);
            end
        end
        unionTop = '0;
        foreach (items[i]) begin
            unionTop |= items[i];
        end
        loadTop(unionTop);
        randomSlow = toggleSlow;
        foreach (items[i]) begin
            modelItem(currentTop, items[i], ends[i]);
            pushItem(items[i], ends[i]);
        end
        drain();
    endtask

    // Fill the buffer and the FIFO with one-item batches until almostFull
    task automatic holdSlowDown();
        botT item;
        int  pushed;
        pushed = 0;
        slowDown = 1'b1;
        nextCycle();
        while (!almostFull && pushed < WAIT_LIMIT) begin
            item = randomBot();
            modelItem(currentTop, item, 1'b1);
            pushItem(item, 1'b1);
            pushed++;
        end
        if (!almostFull) begin
            otherErrors++;
            $display("almostFull never rose while slowDown was held high");
        end
        repeat (10) nextCycle();
        drain();
    endtask

    // Outputs are sampled on the falling edge
    always @(negedge clk) begin
        if (!rst && resultValid) begin
            if (expectSums.size() == 0) begin
                otherErrors++;
                $display("resultValid pulsed while no result was expected");
            end else begin
                compareSum(pcoeffSum, expectSums.pop_front());
                compareCount(pcoeffCount, expectCounts.pop_front());
            end
        end
    end

    initial begin
        botT single;
        rst = 1'b1;
        writeTop = 1'b0;
        topValue = '0;
        writeBot = 1'b0;
        botValue = '0;
        batchEnd = 1'b0;
        slowDown = 1'b0;
        currentTop = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle pipeline after reset
        for (int i = 0; i < 30; i++) begin
            if (almostFull !== 1'b0) begin
                otherErrors++;
                $display("almostFull is not low on an idle pipeline after reset");
            end
            if (resultValid !== 1'b0) begin
                otherErrors++;
                $display("resultValid is not low on an idle pipeline after reset");
            end
            nextCycle();
        end

        // Top all ones so every lane hits
        loadTop('1);
        single = randomBot();
        modelItem(currentTop, single, 1'b1);
        pushItem(single, 1'b1);
        drain();

        // Drained runs with a new top each
        runBatches(6, 1'b0);
        runBatches(6, 1'b0);

        // Back-pressure from random and from held slowDown
        runBatches(8, 1'b1);
        holdSlowDown();
        runBatches(5, 1'b1);

        finishRun();
    end

endmodule

/* flist.f */
+incdir+sim
logic/boolFuncPkg.sv
logic/resultPkg.sv
logic/delayLine.sv
logic/botFifo.sv
logic/variableSwapper.sv
logic/subsetAccumulator.sv
logic/resultBuffer.sv
logic/sumTree.sv
logic/permutationPipeline.sv
sim/permutationPipelineTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= permutationPipelineTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS PASS_TEXT"

# The run passes only if the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
